// File: design/eth_pe_core.sv
// protocol engine core top with sma master, mdc divider, shifter and fifos
`default_nettype none
`timescale 1ns/100ps
`include "eth_sma_defines.svh"

module eth_pe_core (
	input  wire logic                    pe_clk,
	input  wire logic                    reset,
	// command side
	input  wire logic                    cmd_we,
	input  wire eth_sma_pkg::sma_cmd_t   cmd_data,
	output logic [`ETH_SMA_NUM_W-1:0]    cmd_num,
	// read side
	input  wire logic                    rd_re,
	output eth_sma_pkg::sma_rdata_t      rd_data,
	output logic [`ETH_SMA_NUM_W-1:0]    rd_num,
	// control
	input  wire logic                    master_logic_clr,
	input  wire logic                    master_enable,
	output logic                         master_end,
	// config
	input  wire logic [7:0]              r0_clkdiv,
	input  wire logic [4:0]              r0_phyadr,
	input  wire logic [7:0]              r0_interval_bit,
	// interrupt status
	output logic                         int0_status_rx_turn_nack,
	output logic                         int0_status_master_frame_done,
	// pins
	output logic                         eth_mdc,
	output logic                         eth_mdc_oen,
	output logic                         eth_mdio_o,
	input  wire logic                    eth_mdio_i,
	output logic                         eth_mdio_oen
);

	import eth_sma_pkg::*;

	sma_cmd_t   tx_head;
	sma_rdata_t rx_fifo_data;
	logic       tx_fifo_re;
	logic       tx_empty;
	logic       rx_fifo_we;
	logic       rx_full;
	logic       load;
	logic       mdc_run;
	logic       mdc_rise;
	logic       mdc_fall;
	logic       frame_done;
	logic       nack;

	//==========================================================
	// command and read data fifos
	//==========================================================

	eth_sma_fifo #(.payload_t(sma_cmd_t)) u_tx_fifo (
		.pe_clk (pe_clk),
		.reset  (reset),
		.flush  (master_logic_clr),
		.we     (cmd_we),
		.re     (tx_fifo_re),
		.wdata  (cmd_data),
		.rdata  (tx_head),
		.num    (cmd_num),
		.full   (),
		.empty  (tx_empty)
	);

	eth_sma_fifo #(.payload_t(sma_rdata_t)) u_rx_fifo (
		.pe_clk (pe_clk),
		.reset  (reset),
		.flush  (master_logic_clr),
		.we     (rx_fifo_we),
		.re     (rd_re),
		.wdata  (rx_fifo_data),
		.rdata  (rd_data),
		.num    (rd_num),
		.full   (rx_full),
		.empty  ()
	);

	//==========================================================
	// sma master protocol engine
	//==========================================================

	eth_sma_pe_master u_eth_sma_pe_master (
		.pe_clk           (pe_clk),
		.reset            (reset),
		.logic_clr        (master_logic_clr),
		.enable           (master_enable),
		.tx_empty         (tx_empty),
		.tx_head_op       (tx_head.op),
		.rx_full          (rx_full),
		.frame_done       (frame_done),
		.nack             (nack),
		.mdc_rise         (mdc_rise),
		.interval_bit     (r0_interval_bit),
		.tx_fifo_re       (tx_fifo_re),
		.load             (load),
		.mdc_run          (mdc_run),
		.master_end       (master_end),
		.int_frame_done   (int0_status_master_frame_done),
		.int_rx_turn_nack (int0_status_rx_turn_nack)
	);

	eth_sma_mdc_gen u_eth_sma_mdc_gen (
		.pe_clk   (pe_clk),
		.reset    (reset),
		.clr      (master_logic_clr),
		.run      (mdc_run),
		.clkdiv   (r0_clkdiv),
		.mdc      (eth_mdc),
		.mdc_oen  (eth_mdc_oen),
		.mdc_rise (mdc_rise),
		.mdc_fall (mdc_fall)
	);

	eth_sma_shifter u_eth_sma_shifter (
		.pe_clk     (pe_clk),
		.reset      (reset),
		.clr        (master_logic_clr),
		.load       (load),
		.cmd        (tx_head),
		.phyadr     (r0_phyadr),
		.mdc_rise   (mdc_rise),
		.mdc_fall   (mdc_fall),
		.mdio_i     (eth_mdio_i),
		.mdio_o     (eth_mdio_o),
		.mdio_oen   (eth_mdio_oen),
		.frame_done (frame_done),
		.nack       (nack),
		.rx_we      (rx_fifo_we),
		.rx_data    (rx_fifo_data)
	);

endmodule

`default_nettype wire

// File: design/eth_sma_fifo.sv
// synchronous fifo with type parameter payload, occupancy count and flush
`default_nettype none
`timescale 1ns/100ps
`include "eth_sma_defines.svh"

module eth_sma_fifo #(
	parameter type payload_t = logic [15:0]
) (
	input  wire logic                      pe_clk,
	input  wire logic                      reset,
	input  wire logic                      flush,
	input  wire logic                      we,
	input  wire logic                      re,
	input  wire payload_t                  wdata,
	output payload_t                       rdata,
	output logic [`ETH_SMA_NUM_W-1:0]      num,
	output logic                           full,
	output logic                           empty
);

	localparam int depth = `ETH_SMA_FIFO_DEPTH;
	localparam int ptr_w = $clog2(depth);

	payload_t         mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic             do_wr;
	logic             do_rd;

	// write on full and read on empty are dropped
	assign do_wr = we & ~full;
	assign do_rd = re & ~empty;

	assign full  = (num == `ETH_SMA_NUM_W'(depth));
	assign empty = (num == '0);

	// head shown without a pop
	assign rdata = mem[rd_ptr];

	// storage
	always_ff @(posedge pe_clk) begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
	end

	// pointers and count
	always_ff @(posedge pe_clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			num    <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			// count moves only when exactly one side is active
			case ({do_wr, do_rd})
				2'b10:   num <= num + 1'b1;
				2'b01:   num <= num - 1'b1;
				default: num <= num;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/eth_sma_mdc_gen.sv
// mdc clock divider with rise and fall strobes
`default_nettype none
`timescale 1ns/100ps

module eth_sma_mdc_gen (
	input  wire logic       pe_clk,
	input  wire logic       reset,
	input  wire logic       clr,
	input  wire logic       run,
	input  wire logic [7:0] clkdiv,
	output logic            mdc,
	output logic            mdc_oen,
	output logic            mdc_rise,
	output logic            mdc_fall
);

	logic [7:0] div_cnt;
	logic       active;

	// keep going after run drops until mdc is back low
	assign active = run | mdc;

	// master owns mdc, pad always driven
	assign mdc_oen = 1'b0;

	//==========================================================
	// divider
	// half period = clkdiv + 1 pe_clk cycles
	//==========================================================

	always_ff @(posedge pe_clk) begin
		if (reset || clr) begin
			div_cnt  <= '0;
			mdc      <= 1'b0;
			mdc_rise <= 1'b0;
			mdc_fall <= 1'b0;
		end else begin
			mdc_rise <= 1'b0;
			mdc_fall <= 1'b0;
			if (!active) begin
				// parked low, next start begins a full half period
				div_cnt <= '0;
			end else if (div_cnt >= clkdiv) begin
				div_cnt <= '0;
				mdc     <= ~mdc;
				// strobes line up with the first cycle of the new level
				mdc_rise <= ~mdc;
				mdc_fall <= mdc;
			end else begin
				div_cnt <= div_cnt + 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/eth_sma_pe_master.sv
// sma master fsm, enable edge detect and inter frame interval counter
`default_nettype none
`timescale 1ns/100ps

module eth_sma_pe_master (
	input  wire logic                 pe_clk,
	input  wire logic                 reset,
	input  wire logic                 logic_clr,
	input  wire logic                 enable,
	input  wire logic                 tx_empty,
	input  wire eth_sma_pkg::sma_op_t tx_head_op,
	input  wire logic                 rx_full,
	input  wire logic                 frame_done,
	input  wire logic                 nack,
	input  wire logic                 mdc_rise,
	input  wire logic [7:0]           interval_bit,
	output logic                      tx_fifo_re,
	output logic                      load,
	output logic                      mdc_run,
	output logic                      master_end,
	output logic                      int_frame_done,
	output logic                      int_rx_turn_nack
);

	import eth_sma_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,
		st_frame,
		st_gap,
		st_end
	} state_t;

	state_t     state;
	state_t     state_nxt;
	logic       enable_d;
	logic       enable_rise;
	logic       gap_en;
	logic       gap_last;
	logic       fetch_ok;
	logic [7:0] gap_cnt;

	//==========================================================
	// enable edge and gap control
	//==========================================================

	assign enable_rise = enable & ~enable_d;
	assign gap_en      = (interval_bit != 8'd0);

	// interval_bit + 1 rises seen, so at least interval_bit full periods
	assign gap_last = mdc_rise && (gap_cnt == interval_bit);

	// read waits in fetch while rx fifo has no room
	assign fetch_ok = (state == st_fetch) && !tx_empty &&
		!(tx_head_op == sma_op_read && rx_full);

	// pop and load share the cycle, shifter grabs the head
	assign load       = fetch_ok;
	assign tx_fifo_re = fetch_ok;

	// mdc stops in fetch, generator parks it low
	assign mdc_run    = (state == st_frame) || (state == st_gap);
	assign master_end = (state == st_end);

	// frame status straight to the interrupt block
	assign int_frame_done   = frame_done;
	assign int_rx_turn_nack = nack;

	//==========================================================
	// fsm
	//==========================================================

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:  if (enable_rise) state_nxt = st_fetch;
			st_fetch: begin
				if (tx_empty)
					state_nxt = st_end;
				else if (fetch_ok)
					state_nxt = st_frame;
			end
			st_frame: begin
				if (frame_done)
					state_nxt = gap_en ? st_gap : st_fetch;
			end
			st_gap:   if (gap_last) state_nxt = st_fetch;
			st_end:   state_nxt = st_idle;
			default:  state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge pe_clk) begin
		if (reset || logic_clr) begin
			state    <= st_idle;
			enable_d <= 1'b0;
			gap_cnt  <= '0;
		end else begin
			state    <= state_nxt;
			enable_d <= enable;
			// counts mdc periods inside the gap only
			if (state != st_gap)
				gap_cnt <= '0;
			else if (mdc_rise && !gap_last)
				gap_cnt <= gap_cnt + 8'd1;
		end
	end

endmodule

`default_nettype wire

// File: design/eth_sma_pkg.sv
// sma opcode enum, command word struct and read data type
`default_nettype none

package eth_sma_pkg;

	//==========================================================
	// clause 22 opcodes
	//==========================================================

	// only write and read are legal in clause 22
	typedef enum logic [1:0] {
		sma_op_write = 2'b01,
		sma_op_read  = 2'b10
	} sma_op_t;

	//==========================================================
	// tx fifo word
	//==========================================================

	// 23 bit command as loaded by software
	// op sits in the top two bits
	typedef struct packed {
		sma_op_t     op;
		logic [4:0]  reg_adr;
		// ignored on a read
		logic [15:0] wdata;
	} sma_cmd_t;

	//==========================================================
	// rx fifo word
	//==========================================================

	typedef logic [15:0] sma_rdata_t;

endpackage

`default_nettype wire

// File: design/eth_sma_shifter.sv
// mdio frame shift register, turnaround check and read data capture
`default_nettype none
`timescale 1ns/100ps
`include "eth_sma_defines.svh"

module eth_sma_shifter (
	input  wire logic                  pe_clk,
	input  wire logic                  reset,
	input  wire logic                  clr,
	input  wire logic                  load,
	input  wire eth_sma_pkg::sma_cmd_t cmd,
	input  wire logic [4:0]            phyadr,
	input  wire logic                  mdc_rise,
	input  wire logic                  mdc_fall,
	input  wire logic                  mdio_i,
	output logic                       mdio_o,
	output logic                       mdio_oen,
	output logic                       frame_done,
	output logic                       nack,
	output logic                       rx_we,
	output eth_sma_pkg::sma_rdata_t    rx_data
);

	import eth_sma_pkg::*;

	localparam int frame_msb = `ETH_SMA_FRAME_BITS - 1;
	localparam int idx_w     = $clog2(`ETH_SMA_FRAME_BITS);

	// bit positions counted from the first preamble bit
	// st 2 + op 2 + phy 5 + reg 5 ahead of turnaround
	localparam logic [idx_w-1:0] ta1_idx  = idx_w'(`ETH_SMA_PRE_BITS + 14);
	localparam logic [idx_w-1:0] ta2_idx  = idx_w'(`ETH_SMA_PRE_BITS + 15);
	localparam logic [idx_w-1:0] data_idx = idx_w'(`ETH_SMA_PRE_BITS + 16);
	localparam logic [idx_w-1:0] last_idx = idx_w'(frame_msb);

	logic [frame_msb:0] frame_vec;
	logic [frame_msb:0] next_vec;
	logic [idx_w-1:0]   bit_idx;
	logic               busy;
	logic               rose;
	logic               is_read;
	logic               nack_seen;
	logic               cmd_is_read;
	logic               sample_en;
	logic               advance;

	//==========================================================
	// outgoing frame
	//==========================================================

	assign cmd_is_read = (cmd.op == sma_op_read);

	// on a read the ta and data slots are never driven
	assign next_vec = {
		{`ETH_SMA_PRE_BITS{1'b1}},
		2'b01,
		cmd.op,
		phyadr,
		cmd.reg_adr,
		cmd_is_read ? 2'b11 : 2'b10,
		cmd_is_read ? 16'hffff : cmd.wdata
	};

	// a fall only counts once the current bit was seen by a rise
	// covers mdc still high from the previous gap at load
	assign sample_en = busy & mdc_rise & ~load;
	assign advance   = busy & mdc_fall & rose & ~load;

	// payload shift register
	always_ff @(posedge pe_clk) begin
		if (load)
			frame_vec <= next_vec;
		else if (advance)
			frame_vec <= frame_vec << 1;
	end

	// read data, msb first
	always_ff @(posedge pe_clk) begin
		if (sample_en && is_read && bit_idx >= data_idx)
			rx_data <= {rx_data[14:0], mdio_i};
	end

	//==========================================================
	// bit sequencing
	//==========================================================

	always_ff @(posedge pe_clk) begin
		if (reset || clr) begin
			busy       <= 1'b0;
			rose       <= 1'b0;
			is_read    <= 1'b0;
			nack_seen  <= 1'b0;
			bit_idx    <= '0;
			mdio_o     <= 1'b1;
			mdio_oen   <= 1'b1;
			frame_done <= 1'b0;
			nack       <= 1'b0;
			rx_we      <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			nack       <= 1'b0;
			rx_we      <= 1'b0;
			if (load) begin
				busy      <= 1'b1;
				rose      <= 1'b0;
				is_read   <= cmd_is_read;
				nack_seen <= 1'b0;
				bit_idx   <= '0;
				// first preamble bit, a one like the idle level
				mdio_o    <= next_vec[frame_msb];
				mdio_oen  <= 1'b0;
			end else if (sample_en) begin
				rose <= 1'b1;
				// phy must pull low in the second ta bit
				if (is_read && bit_idx == ta2_idx)
					nack_seen <= mdio_i;
			end else if (advance) begin
				rose <= 1'b0;
				if (bit_idx == last_idx) begin
					busy       <= 1'b0;
					frame_done <= 1'b1;
					nack       <= nack_seen;
					rx_we      <= is_read & ~nack_seen;
					// back to driving idle high
					mdio_o     <= 1'b1;
					mdio_oen   <= 1'b0;
				end else begin
					bit_idx <= bit_idx + 1'b1;
					mdio_o  <= frame_vec[frame_msb-1];
					// read hands the line over from ta onward
					if (is_read && bit_idx == ta1_idx - 1'b1)
						mdio_oen <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
design/eth_sma_pkg.sv
design/eth_sma_fifo.sv
design/eth_sma_mdc_gen.sv
design/eth_sma_shifter.sv
design/eth_sma_pe_master.sv
design/eth_pe_core.sv
verification/eth_sma_phy_model.sv
verification/eth_sma_checker.sv
verification/eth_pe_core_tb.sv

// File: include/eth_sma_defines.svh
// sma fifo depth, occupancy count width, preamble and frame length macros
`ifndef ETH_SMA_DEFINES_SVH
`define ETH_SMA_DEFINES_SVH

//==========================================================
// fifo sizing
//==========================================================

// entries per fifo, tx commands and rx read data alike
`define ETH_SMA_FIFO_DEPTH 4
// occupancy count, holds 0 up to depth
`define ETH_SMA_NUM_W 3

//==========================================================
// mdio frame layout
//==========================================================

// preamble ones ahead of the start bits
`define ETH_SMA_PRE_BITS 32
// preamble + st + op + phy + reg + ta + data
`define ETH_SMA_FRAME_BITS 64

`endif

// File: verification/eth_pe_core_tb.sv
// testbench for the protocol engine core with phy model, reference function and read compare
`default_nettype none
`timescale 1ns/100ps
`include "eth_sma_defines.svh"

module eth_pe_core_tb;

	import eth_sma_pkg::*;

	logic                       pe_clk = 1'b0;
	logic                       reset;
	logic                       cmd_we;
	sma_cmd_t                   cmd_data;
	logic [`ETH_SMA_NUM_W-1:0]  cmd_num;
	logic                       rd_re;
	sma_rdata_t                 rd_data;
	logic [`ETH_SMA_NUM_W-1:0]  rd_num;
	logic                       master_logic_clr;
	logic                       master_enable;
	logic                       master_end;
	logic [7:0]                 r0_clkdiv;
	logic [4:0]                 r0_phyadr;
	logic [7:0]                 r0_interval_bit;
	logic                       int0_status_rx_turn_nack;
	logic                       int0_status_master_frame_done;
	logic                       eth_mdc;
	logic                       eth_mdc_oen;
	logic                       eth_mdio_o;
	logic                       eth_mdio_i;
	logic                       eth_mdio_oen;
	logic                       withhold_ta;

	// shadow of phy registers as the writes issued leave them
	logic [15:0] shadow [32];
	logic [15:0] exp_q [$];
	int          seed = 32'h5b94;
	int          done_cnt = 0;
	int          end_cnt = 0;
	int          nack_cnt = 0;
	int          checked_cnt = 0;
	bit          drain_en = 1'b1;
	string       test_name = "reset";

	eth_pe_core i_eth_pe_core (.*);

	eth_sma_phy_model u_phy (
		.mdc         (eth_mdc),
		.mdio_o      (eth_mdio_o),
		.mdio_oen    (eth_mdio_oen),
		.withhold_ta (withhold_ta),
		.mdio_i      (eth_mdio_i)
	);

	bind eth_pe_core eth_sma_checker u_checker (
		.pe_clk                        (pe_clk),
		.reset                         (reset),
		.master_logic_clr              (master_logic_clr),
		.eth_mdc                       (eth_mdc),
		.eth_mdio_o                    (eth_mdio_o),
		.eth_mdio_oen                  (eth_mdio_oen),
		.master_end                    (master_end),
		.int0_status_rx_turn_nack      (int0_status_rx_turn_nack),
		.int0_status_master_frame_done (int0_status_master_frame_done)
	);

	// 40 ns period
	always #20 pe_clk = ~pe_clk;

	always @(posedge pe_clk) begin
		if (int0_status_master_frame_done)
			done_cnt++;
		if (master_end)
			end_cnt++;
		if (int0_status_rx_turn_nack)
			nack_cnt++;
	end

	//============================================================
	// helpers
	//============================================================

	function automatic logic [15:0] expected_read(input logic [4:0] adr);
		return shadow[adr];
	endfunction

	// inputs move 2 ns after the edge
	task automatic step();
		@(posedge pe_clk);
		#2;
	endtask

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else report_fail($sformatf("** Error %s %s: expected %0h, actual %0h",
			test_name, what, exp, act));
	endtask

	task automatic check_true(input bit cond, input string msg);
		assert (cond)
		else report_fail(msg);
	endtask

	task automatic push_cmd(input sma_op_t op, input logic [4:0] adr, input logic [15:0] wdata,
		input bit expect_word = 1'b1);
		cmd_data = '{op: op, reg_adr: adr, wdata: wdata};
		cmd_we = 1'b1;
		if (op == sma_op_write)
			shadow[adr] = wdata;
		else if (expect_word)
			exp_q.push_back(expected_read(adr));
		step();
		cmd_we = 1'b0;
	endtask

	task automatic start_engine();
		master_enable = 1'b0;
		step();
		master_enable = 1'b1;
		step();
	endtask

	// frames, end pulses and, when draining, the read queue all settled
	task automatic wait_until_idle(input int n_done, input int n_end);
		int n;
		n = 0;
		while (done_cnt < n_done || end_cnt < n_end ||
			(drain_en && (exp_q.size() != 0 || rd_num != 0))) begin
			step();
			n++;
			if (n > 20000)
				report_fail($sformatf("timeout in %s waiting for the engine to finish", test_name));
		end
	endtask

	task automatic wait_frame_done(input int n_done);
		int n;
		n = 0;
		while (done_cnt < n_done) begin
			step();
			n++;
			if (n > 20000)
				report_fail($sformatf("timeout in %s waiting for frame done", test_name));
		end
	endtask

	// cycles until the next mdc rise
	task automatic wait_mdc_rise(output int cycles);
		logic prev;
		cycles = 0;
		do begin
			prev = eth_mdc;
			step();
			cycles++;
			if (cycles > 2000)
				report_fail($sformatf("timeout in %s waiting for an mdc rise", test_name));
		end while (!(eth_mdc && !prev));
	endtask

	// mdc rises from one frame done to the next, oen low through the gap
	task automatic count_gap_rises(output int rises);
		logic prev;
		int   n;
		rises = 0;
		n = 0;
		do begin
			prev = eth_mdc;
			step();
			n++;
			if (eth_mdc && !prev)
				rises++;
			// every cycle of the first 5 gap periods
			if (rises <= 5)
				check_value("gap mdio_oen", 0, eth_mdio_oen);
			if (n > 20000)
				report_fail($sformatf("timeout in %s waiting for the next frame", test_name));
		end while (!int0_status_master_frame_done);
	endtask

	//============================================================
	// compare process, pops the read fifo
	//============================================================

	initial begin
		forever begin
			step();
			rd_re = 1'b0;
			if (drain_en && rd_num != 0) begin
				if (exp_q.size() == 0)
					report_fail("read fifo holds a word that no read command asked for");
				check_value("read data", exp_q.pop_front(), rd_data);
				checked_cnt++;
				rd_re = 1'b1;
			end
		end
	end

	//============================================================
	// stimulus
	//============================================================

	initial begin
		logic [4:0] adr [4];
		int         rnd;
		int         d0;
		int         e0;
		int         c0;
		int         n0;
		int         cycles;
		int         rises;

		for (int i = 0; i < 32; i++)
			shadow[i] = 16'(i);
		reset = 1'b1;
		cmd_we = 1'b0;
		cmd_data = '0;
		rd_re = 1'b0;
		master_logic_clr = 1'b0;
		master_enable = 1'b0;
		r0_clkdiv = 8'd1;
		r0_phyadr = 5'h03;
		r0_interval_bit = 8'd0;
		withhold_ta = 1'b0;
		repeat (16) step();
		reset = 1'b0;
		step();

		// pins, pulses and fifos as reset leaves them
		check_value("mdc", 0, eth_mdc);
		check_value("mdc_oen", 0, eth_mdc_oen);
		check_value("mdio_oen", 1, eth_mdio_oen);
		check_value("pulses", 0,
			{master_end, int0_status_rx_turn_nack, int0_status_master_frame_done});
		check_value("cmd_num", 0, cmd_num);
		check_value("rd_num", 0, rd_num);

		// write then read back
		test_name = "write_read";
		d0 = done_cnt;
		e0 = end_cnt;
		c0 = checked_cnt;
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			adr[i] = rnd[4:0];
			rnd = $random(seed);
			push_cmd(sma_op_write, adr[i], rnd[15:0]);
		end
		start_engine();
		wait_until_idle(d0 + 4, e0 + 1);
		for (int i = 0; i < 4; i++)
			push_cmd(sma_op_read, adr[i], 16'h0000);
		start_engine();
		wait_until_idle(d0 + 8, e0 + 2);
		check_value("frame done count", d0 + 8, done_cnt);
		check_value("reads checked", c0 + 4, checked_cnt);

		// mdc period at clkdiv 3
		test_name = "clock_divider";
		r0_clkdiv = 8'd3;
		d0 = done_cnt;
		e0 = end_cnt;
		push_cmd(sma_op_read, adr[0], 16'h0000);
		start_engine();
		wait_mdc_rise(cycles);
		wait_mdc_rise(cycles);
		check_value("mdc period", 8, cycles);
		wait_until_idle(d0 + 1, e0 + 1);

		// turnaround withheld on the first read
		test_name = "turnaround_nack";
		r0_clkdiv = 8'd1;
		d0 = done_cnt;
		e0 = end_cnt;
		c0 = checked_cnt;
		n0 = nack_cnt;
		withhold_ta = 1'b1;
		push_cmd(sma_op_read, adr[1], 16'h0000, 1'b0);
		push_cmd(sma_op_read, adr[2], 16'h0000);
		start_engine();
		wait_frame_done(d0 + 1);
		withhold_ta = 1'b0;
		wait_until_idle(d0 + 2, e0 + 1);
		check_value("nack count", n0 + 1, nack_cnt);
		check_value("reads checked", c0 + 1, checked_cnt);

		// interval between frames and end pulse
		test_name = "end_interval";
		r0_interval_bit = 8'd5;
		drain_en = 1'b0;
		d0 = done_cnt;
		e0 = end_cnt;
		rnd = $random(seed);
		push_cmd(sma_op_write, adr[3], rnd[15:0]);
		push_cmd(sma_op_read, adr[3], 16'h0000);
		rnd = $random(seed);
		push_cmd(sma_op_write, adr[0], rnd[15:0]);
		push_cmd(sma_op_read, adr[0], 16'h0000);
		start_engine();
		wait_frame_done(d0 + 1);
		for (int i = 0; i < 3; i++) begin
			count_gap_rises(rises);
			check_true(rises >= 64 + 5,
				$sformatf("gap in %s shorter than 5 mdc periods (%0d rises)", test_name, rises));
		end
		wait_until_idle(d0 + 4, e0 + 1);
		// room for a second end pulse to show up
		repeat (100) step();
		check_value("end count", e0 + 1, end_cnt);
		check_value("rd_num", 2, rd_num);
		drain_en = 1'b1;
		wait_until_idle(d0 + 4, e0 + 1);
		r0_interval_bit = 8'd0;

		// full read fifo holds the next read
		test_name = "back_pressure";
		drain_en = 1'b0;
		d0 = done_cnt;
		e0 = end_cnt;
		c0 = checked_cnt;
		for (int i = 0; i < 4; i++)
			push_cmd(sma_op_read, adr[i], 16'h0000);
		start_engine();
		wait_until_idle(d0 + 4, e0 + 1);
		check_value("rd_num full", 4, rd_num);
		rnd = $random(seed);
		push_cmd(sma_op_read, rnd[4:0], 16'h0000);
		start_engine();
		repeat (400) begin
			step();
			check_value("held frame count", d0 + 4, done_cnt);
			check_value("held rd_num", 4, rd_num);
		end
		check_value("held cmd_num", 1, cmd_num);
		drain_en = 1'b1;
		wait_until_idle(d0 + 5, e0 + 2);
		check_value("reads checked", c0 + 5, checked_cnt);

		// clear in the middle of a frame
		test_name = "logic_clear";
		drain_en = 1'b0;
		d0 = done_cnt;
		// read word parked in the rx fifo for the flush to drop
		push_cmd(sma_op_read, 5'h1d, 16'h0000, 1'b0);
		push_cmd(sma_op_write, 5'h1f, 16'ha5a5);
		push_cmd(sma_op_write, 5'h1e, 16'h5a5a);
		start_engine();
		wait_frame_done(d0 + 1);
		repeat (20) wait_mdc_rise(cycles);
		check_value("rd_num before clear", 1, rd_num);
		master_logic_clr = 1'b1;
		step();
		master_logic_clr = 1'b0;
		check_value("mdc", 0, eth_mdc);
		check_value("mdc_oen", 0, eth_mdc_oen);
		check_value("mdio_oen", 1, eth_mdio_oen);
		check_value("cmd_num", 0, cmd_num);
		check_value("rd_num", 0, rd_num);
		repeat (600) begin
			step();
			check_value("frame done after clear", d0 + 1, done_cnt);
		end

		if (exp_q.size() == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			report_fail("expected read words left over at the end");
		end
	end

endmodule

`default_nettype wire

// File: verification/eth_sma_checker.sv
// bound assertions for mdio timing, one cycle pulses and pin state after reset
`default_nettype none
`timescale 1ns/100ps

module eth_sma_checker (
	input wire logic pe_clk,
	input wire logic reset,
	input wire logic master_logic_clr,
	input wire logic eth_mdc,
	input wire logic eth_mdio_o,
	input wire logic eth_mdio_oen,
	input wire logic master_end,
	input wire logic int0_status_rx_turn_nack,
	input wire logic int0_status_master_frame_done
);

	//============================================================
	// pin rules
	//============================================================

	// mdio moves only one cycle after mdc fell, clear excepted
	a_mdio_after_fall: assert property (@(posedge pe_clk) disable iff (reset)
		$changed(eth_mdio_o) && !$past(master_logic_clr) |-> !$past(eth_mdc) && $past(eth_mdc, 2))
		else $error("mdio output changed away from an mdc falling edge");

	a_oen_after_reset: assert property (@(posedge pe_clk) $fell(reset) |-> eth_mdio_oen)
		else $error("mdio not released after reset");

	// pulses
	a_end_pulse: assert property (@(posedge pe_clk) disable iff (reset)
		master_end |=> !master_end)
		else $error("master end held longer than one cycle");

	a_nack_pulse: assert property (@(posedge pe_clk) disable iff (reset)
		int0_status_rx_turn_nack |=> !int0_status_rx_turn_nack)
		else $error("turnaround nack held longer than one cycle");

	a_done_pulse: assert property (@(posedge pe_clk) disable iff (reset)
		int0_status_master_frame_done |=> !int0_status_master_frame_done)
		else $error("frame done held longer than one cycle");

endmodule

`default_nettype wire

// File: verification/eth_sma_phy_model.sv
// behavioral clause 22 phy with a 32 entry register file and turnaround withhold
`default_nettype none
`timescale 1ns/100ps

module eth_sma_phy_model (
	input  wire logic mdc,
	input  wire logic mdio_o,
	input  wire logic mdio_oen,
	input  wire logic withhold_ta,
	output logic      mdio_i
);

	logic [15:0] regs [32];
	logic [12:0] hdr;
	logic [15:0] wd;
	logic [4:0]  adr;
	logic        in_frame = 1'b0;
	logic        rd_op = 1'b0;
	int          ones = 0;
	int          pos = 0;

	// registers power up as their own address
	initial begin
		for (int i = 0; i < 32; i++)
			regs[i] = 16'(i);
		mdio_i = 1'b1;
	end

	//============================================================
	// receive side, sampled on mdc rise
	//============================================================

	always @(posedge mdc) begin
		if (!in_frame) begin
			if (mdio_oen)
				ones = 0;
			else if (mdio_o)
				ones++;
			// first start bit after a full preamble
			else if (ones >= 32) begin
				in_frame = 1'b1;
				pos = 33;
			end else
				ones = 0;
		end else begin
			// st1, op, phy and reg bits
			if (pos <= 45)
				hdr = {hdr[11:0], mdio_o};
			if (pos == 45) begin
				rd_op = (hdr[11:10] == 2'b10);
				adr = hdr[4:0];
			end
			if (pos >= 48)
				wd = {wd[14:0], mdio_o};
			if (pos == 63) begin
				if (!rd_op)
					regs[adr] = wd;
				in_frame = 1'b0;
				ones = 0;
			end
			pos++;
		end
	end

	// drive side, changes on mdc fall
	always @(negedge mdc) begin
		if (in_frame && rd_op && pos == 47)
			mdio_i <= withhold_ta;
		else if (in_frame && rd_op && pos >= 48)
			mdio_i <= regs[adr][63 - pos];
		else
			mdio_i <= 1'b1;
	end

endmodule

`default_nettype wire
